/* verilog/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;

  // access size in funct3, bit 2 marks zero extension
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  localparam logic [2:0] F3_ADDI = 3'b000; // only op-imm function kept

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    cls_alu_imm,
    cls_auipc,
    cls_lui,
    cls_jal,
    cls_jalr,
    cls_load,
    cls_store,
    cls_nop
  } op_class_e;

  typedef struct packed {
    op_class_e  op_class;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] funct3;
    word_t      imm;     // already sign extended
  } decoded_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;   // rs2, not yet lane shifted
    logic [2:0] funct3;
    logic       is_load;
    logic       is_store;
  } mem_req_t;

  typedef struct packed {
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
    logic       we;
    logic       cyc;
    logic       stb;
  } wb_m2s_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_s2m_t;

endpackage

/* verilog/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
  input  rv_pkg::word_t    inst,
  output rv_pkg::decoded_t dec
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_s;
  rv_pkg::word_t     imm_u;
  rv_pkg::word_t     imm_j;
  rv_pkg::op_class_e op_class;
  rv_pkg::word_t     imm;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // immediates, all sign extended from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op_class = rv_pkg::cls_nop; // anything unknown retires as a no-op
    case (opcode)
      rv_pkg::OPC_OP_IMM: begin
        if (funct3 == rv_pkg::F3_ADDI) op_class = rv_pkg::cls_alu_imm;
      end
      rv_pkg::OPC_AUIPC: op_class = rv_pkg::cls_auipc;
      rv_pkg::OPC_LUI:   op_class = rv_pkg::cls_lui;
      rv_pkg::OPC_JAL:   op_class = rv_pkg::cls_jal;
      rv_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) op_class = rv_pkg::cls_jalr;
      end
      rv_pkg::OPC_LOAD: begin
        case (funct3)
          rv_pkg::F3_B, rv_pkg::F3_H, rv_pkg::F3_W,
          rv_pkg::F3_BU, rv_pkg::F3_HU: op_class = rv_pkg::cls_load;
          default:                      op_class = rv_pkg::cls_nop;
        endcase
      end
      rv_pkg::OPC_STORE: begin
        case (funct3)
          rv_pkg::F3_B, rv_pkg::F3_H, rv_pkg::F3_W: op_class = rv_pkg::cls_store;
          default:                                  op_class = rv_pkg::cls_nop;
        endcase
      end
      default: op_class = rv_pkg::cls_nop;
    endcase
  end

  // pick the immediate format for the class
  always_comb begin
    case (op_class)
      rv_pkg::cls_alu_imm,
      rv_pkg::cls_jalr,
      rv_pkg::cls_load:  imm = imm_i;
      rv_pkg::cls_store: imm = imm_s;
      rv_pkg::cls_auipc,
      rv_pkg::cls_lui:   imm = imm_u;
      rv_pkg::cls_jal:   imm = imm_j;
      default:           imm = '0;
    endcase
  end

  assign dec.op_class = op_class;
  assign dec.rd       = inst[11:7];
  assign dec.rs1      = inst[19:15];
  assign dec.rs2      = inst[24:20];
  assign dec.funct3   = funct3;
  assign dec.imm      = imm;

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data
);

  rv_pkg::word_t regs [1:31]; // no storage behind x0

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 always reads back zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    load_data,
  input  logic             mem_done,
  output rv_pkg::word_t    pc,
  output logic             wr_en,
  output rv_pkg::word_t    wr_data,
  output rv_pkg::mem_req_t mem_req
);

  logic          is_load;
  logic          is_store;
  logic          writes_rd;
  logic          stall;
  rv_pkg::word_t op_a;
  rv_pkg::word_t sum;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t next_pc;

  assign is_load  = (dec.op_class == rv_pkg::cls_load);
  assign is_store = (dec.op_class == rv_pkg::cls_store);

  // first adder operand, second is always the immediate
  always_comb begin
    case (dec.op_class)
      rv_pkg::cls_lui:   op_a = '0;
      rv_pkg::cls_auipc,
      rv_pkg::cls_jal:   op_a = pc;
      default:           op_a = rs1_data;
    endcase
  end

  assign sum      = op_a + dec.imm;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    writes_rd = 1'b1;
    wr_data   = sum;
    next_pc   = pc_plus4;
    case (dec.op_class)
      rv_pkg::cls_jal: begin
        wr_data = pc_plus4; // link
        next_pc = sum;
      end
      rv_pkg::cls_jalr: begin
        wr_data = pc_plus4;
        next_pc = {sum[rv_pkg::XLEN-1:1], 1'b0};
      end
      rv_pkg::cls_load:  wr_data = load_data;
      rv_pkg::cls_store: writes_rd = 1'b0;
      rv_pkg::cls_nop:   writes_rd = 1'b0;
      default:           writes_rd = 1'b1; // alu_imm, auipc, lui
    endcase
  end

  // memory op holds everything until the bus acks
  assign stall = (is_load || is_store) && !mem_done;
  assign wr_en = writes_rd && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_pkg::RESET_PC;
    end else if (!stall) begin
      pc <= next_pc;
    end
  end

  assign mem_req.addr     = sum;
  assign mem_req.wdata    = rs2_data;
  assign mem_req.funct3   = dec.funct3;
  assign mem_req.is_load  = is_load;
  assign mem_req.is_store = is_store;

endmodule

/* verilog/rv_lsu.sv */
`timescale 1ns/100ps

module rv_lsu (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::mem_req_t mem_req,
  output rv_pkg::wb_m2s_t  wb_out,
  input  rv_pkg::wb_s2m_t  wb_in,
  output rv_pkg::word_t    load_data,
  output logic             mem_done
);

  typedef enum logic {
    st_idle,
    st_busy
  } lsu_state_e;

  lsu_state_e    state;
  logic          start;
  logic [3:0]    sel_next;
  rv_pkg::word_t adr_q;
  rv_pkg::word_t dat_q;
  logic [3:0]    sel_q;
  logic          we_q;
  logic [2:0]    funct3_q;
  rv_pkg::word_t rd_shifted;

  assign start    = (state == st_idle) && (mem_req.is_load || mem_req.is_store);
  assign mem_done = (state == st_busy) && wb_in.ack;

  // byte enables from size and low address bits
  always_comb begin
    case (mem_req.funct3)
      rv_pkg::F3_B,
      rv_pkg::F3_BU: sel_next = 4'b0001 << mem_req.addr[1:0];
      rv_pkg::F3_H,
      rv_pkg::F3_HU: sel_next = 4'b0011 << {mem_req.addr[1], 1'b0};
      rv_pkg::F3_W:  sel_next = 4'b1111;
      default:       sel_next = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      we_q  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_busy;
            we_q  <= mem_req.is_store;
          end
        end
        st_busy: begin
          if (wb_in.ack) begin // one beat per request
            state <= st_idle;
            we_q  <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // request payload, captured once and held until ack
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q    <= mem_req.addr;
      dat_q    <= mem_req.wdata << {mem_req.addr[1:0], 3'b000}; // into its lane
      sel_q    <= sel_next;
      funct3_q <= mem_req.funct3;
    end
  end

  assign wb_out.adr = adr_q;
  assign wb_out.dat = dat_q;
  assign wb_out.sel = sel_q;
  assign wb_out.we  = we_q;
  assign wb_out.cyc = (state == st_busy);
  assign wb_out.stb = (state == st_busy);

  // addressed lane down to bit 0, then extend
  assign rd_shifted = wb_in.dat >> {adr_q[1:0], 3'b000};

  always_comb begin
    case (funct3_q)
      rv_pkg::F3_B:  load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
      rv_pkg::F3_H:  load_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
      rv_pkg::F3_BU: load_data = {24'h00_0000, rd_shifted[7:0]};
      rv_pkg::F3_HU: load_data = {16'h0000, rd_shifted[15:0]};
      default:       load_data = wb_in.dat; // lw
    endcase
  end

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::word_t   inst,
  input  rv_pkg::wb_s2m_t wb_in,
  output rv_pkg::word_t   pc,
  output rv_pkg::wb_m2s_t wb_out
);

  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    load_data;
  rv_pkg::word_t    wr_data;
  rv_pkg::mem_req_t mem_req;
  logic             wr_en;
  logic             mem_done;

  rv_decode rv_decode_i (
    .inst (inst),
    .dec  (dec)
  );

  // write index comes straight from the decoded rd
  rv_regfile rv_regfile_i (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (dec.rd),
    .wr_data  (wr_data)
  );

  rv_execute rv_execute_i (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .load_data (load_data),
    .mem_done  (mem_done),
    .pc        (pc),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .mem_req   (mem_req)
  );

  rv_lsu rv_lsu_i (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .wb_out    (wb_out),
    .wb_in     (wb_in),
    .load_data (load_data),
    .mem_done  (mem_done)
  );

endmodule

/* bench/rv_core_assertions.sv */
`timescale 1ns/100ps

module rv_core_assertions (
  input logic            clk,
  input logic            reset,
  input rv_pkg::wb_m2s_t wb_out,
  input rv_pkg::wb_s2m_t wb_in
);

  stb_needs_cyc: assert property (
    @(posedge clk) disable iff (reset) wb_out.stb |-> wb_out.cyc
  ) else $error("wishbone stb high while cyc is low");

  // request must not move until the slave acks
  req_stable: assert property (
    @(posedge clk) disable iff (reset)
    (wb_out.stb && !wb_in.ack) |=> ($stable(wb_out.adr) && $stable(wb_out.sel) &&
                                    $stable(wb_out.we) && $stable(wb_out.dat))
  ) else $error("wishbone request changed before ack");

  sel_nonzero: assert property (
    @(posedge clk) disable iff (reset) wb_out.stb |-> (wb_out.sel != 4'b0000)
  ) else $error("wishbone stb high with no byte selected");

  cyc_drops: assert property (
    @(posedge clk) disable iff (reset) (wb_out.cyc && wb_in.ack) |=> !wb_out.cyc
  ) else $error("wishbone cyc still high after the ack edge");

endmodule

bind rv_lsu rv_core_assertions rv_core_assertions_i (
  .clk    (clk),
  .reset  (reset),
  .wb_out (wb_out),
  .wb_in  (wb_in)
);

/* bench/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

  localparam int N_RANDOM   = 200;
  localparam int N_DUMP     = 32;
  localparam int PROG_LEN   = N_RANDOM + N_DUMP + 8;
  localparam int MAX_CYCLES = N_RANDOM * 5 + 50;
  localparam logic [31:0] WIN_BASE = 32'h0000_0100; // 256-byte data window
  localparam logic [31:0] NOP      = 32'h0000_0013;
  // behavior indices: reset, seq, store, load, wait, x0
  localparam int B_RST = 0;
  localparam int B_SEQ = 1;
  localparam int B_ST  = 2;
  localparam int B_LD  = 3;
  localparam int B_WT  = 4;
  localparam int B_X0  = 5;

  logic            clk;
  logic            reset = 1'b1;
  rv_pkg::word_t   inst;
  rv_pkg::wb_s2m_t wb_in = '0;
  rv_pkg::word_t   pc;
  rv_pkg::wb_m2s_t wb_out;

  logic [31:0]   seed = 32'd39;
  rv_pkg::word_t prog [0:PROG_LEN-1];
  logic [31:0]   end_pc;
  logic [7:0]    slave_mem [0:255];
  logic [7:0]    model_mem [0:255];
  rv_pkg::word_t model_regs [0:31];
  logic          from_load [0:31]; // register last written by a load
  rv_pkg::word_t model_pc;
  logic          in_req = 1'b0;
  int            wait_left = 0;
  int            edges = 0;
  bit            seen_mem = 1'b0;
  int            n_chk [0:5];
  int            n_err [0:5];

  rv_core_top rv_core_top_i (
    .clk    (clk),
    .reset  (reset),
    .inst   (inst),
    .wb_in  (wb_in),
    .pc     (pc),
    .wb_out (wb_out)
  );

  function automatic int unsigned rnd(input int unsigned n);
    seed = seed * 32'd1103515245 + 32'd12345; // lcg step
    return (seed >> 16) % n;
  endfunction

  function automatic logic [7:0] init_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9E37_79B1;
    return h[31:24] ^ h[15:8] ^ h[7:0];
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  function automatic rv_pkg::word_t rom_lookup(input rv_pkg::word_t a);
    logic [31:0] idx;
    idx = (a - rv_pkg::RESET_PC) >> 2;
    if (a[1:0] != 2'b00 || idx >= PROG_LEN) return NOP;
    return prog[idx];
  endfunction

  task automatic gen_program();
    int i;
    int lim;
    int step;
    logic [4:0] rd;
    logic [4:0] rs;
    logic [2:0] f3;
    logic [7:0] off;
    logic [N_RANDOM:0] landing; // slots that some jump lands on
    for (i = 0; i < PROG_LEN; i++) prog[i] = NOP;
    landing = '0;
    i = 0;
    while (i < N_RANDOM) begin
      rd = 5'(rnd(32));
      rs = 5'(rnd(32));
      case (rnd(8))
        0, 1: prog[i] = enc_i(rv_pkg::OPC_OP_IMM, rd, rv_pkg::F3_ADDI, rs, 12'(rnd(4096)));
        2: prog[i] = {4'(rnd(16)), 16'(rnd(65536)), rd, rv_pkg::OPC_LUI};
        3: prog[i] = {4'(rnd(16)), 16'(rnd(65536)), rd, rv_pkg::OPC_AUIPC};
        4: begin
          lim = (N_RANDOM - i < 4) ? N_RANDOM - i : 4; // stay inside the random part
          step = 1 + int'(rnd(lim));
          prog[i] = enc_j(rd, 21'(4 * step));
          landing[i + step] = 1'b1;
        end
        5: begin
          // a jump onto the jalr would skip the auipc that builds its base
          if (i + 1 < N_RANDOM && !landing[i + 1]) begin
            rs = 5'(1 + rnd(31));
            lim = (N_RANDOM - i - 1 < 3) ? N_RANDOM - i - 1 : 3;
            step = int'(rnd(lim));
            prog[i] = {20'h00000, rs, rv_pkg::OPC_AUIPC}; // jalr base
            i++;
            prog[i] = enc_i(rv_pkg::OPC_JALR, rd, 3'b000, rs,
                            12'(8 + 4 * step + int'(rnd(2))));
            landing[i + 1 + step] = 1'b1;
          end
        end
        6: begin
          case (rnd(5))
            0: f3 = rv_pkg::F3_B;
            1: f3 = rv_pkg::F3_H;
            2: f3 = rv_pkg::F3_W;
            3: f3 = rv_pkg::F3_BU;
            default: f3 = rv_pkg::F3_HU;
          endcase
          off = 8'(rnd(256));
          if (f3[1:0] == 2'b01) off[0] = 1'b0;
          if (f3[1:0] == 2'b10) off[1:0] = 2'b00;
          prog[i] = enc_i(rv_pkg::OPC_LOAD, rd, f3, 5'd0, 12'(WIN_BASE + 32'(off)));
        end
        default: begin
          f3 = 3'(rnd(3));
          off = 8'(rnd(256));
          if (f3 == rv_pkg::F3_H) off[0] = 1'b0;
          if (f3 == rv_pkg::F3_W) off[1:0] = 2'b00;
          prog[i] = enc_s(f3, 5'd0, rs, 12'(WIN_BASE + 32'(off)));
        end
      endcase
      i++;
    end
    for (i = 0; i < N_DUMP; i++) begin
      prog[N_RANDOM + i] = enc_s(rv_pkg::F3_W, 5'd0, 5'(i), 12'(WIN_BASE + 32'(4 * i)));
    end
    end_pc = rv_pkg::RESET_PC + 32'(4 * (N_RANDOM + N_DUMP));
  endtask

  function automatic rv_pkg::word_t load_model(input rv_pkg::word_t a, input logic [2:0] f3);
    logic [7:0]    wo;
    rv_pkg::word_t w;
    wo = 8'(a - WIN_BASE) & 8'hFC;
    w = {model_mem[wo + 8'd3], model_mem[wo + 8'd2], model_mem[wo + 8'd1], model_mem[wo]};
    w = w >> (8 * a[1:0]);
    case (f3)
      rv_pkg::F3_B:  return {{24{w[7]}}, w[7:0]};
      rv_pkg::F3_H:  return {{16{w[15]}}, w[15:0]};
      rv_pkg::F3_BU: return {24'h0, w[7:0]};
      rv_pkg::F3_HU: return {16'h0, w[15:0]};
      default:       return w;
    endcase
  endfunction

  // reference model, one instruction per call
  function automatic void step_model(input rv_pkg::word_t ins);
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [2:0]    f3;
    rv_pkg::word_t a;
    rv_pkg::word_t val;
    rv_pkg::word_t nxt;
    logic          wr;
    logic [7:0]    off;
    rd = ins[11:7];
    rs1 = ins[19:15];
    f3 = ins[14:12];
    wr = 1'b0;
    val = '0;
    nxt = model_pc + 32'd4;
    case (ins[6:0])
      rv_pkg::OPC_OP_IMM: begin
        wr = (f3 == rv_pkg::F3_ADDI);
        val = model_regs[rs1] + {{20{ins[31]}}, ins[31:20]};
      end
      rv_pkg::OPC_LUI: begin
        wr = 1'b1;
        val = {ins[31:12], 12'h000};
      end
      rv_pkg::OPC_AUIPC: begin
        wr = 1'b1;
        val = model_pc + {ins[31:12], 12'h000};
      end
      rv_pkg::OPC_JAL: begin
        wr = 1'b1;
        val = model_pc + 32'd4;
        nxt = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      rv_pkg::OPC_JALR: begin
        wr = 1'b1;
        val = model_pc + 32'd4;
        nxt = (model_regs[rs1] + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
      end
      rv_pkg::OPC_LOAD: begin
        wr = 1'b1;
        val = load_model(model_regs[rs1] + {{20{ins[31]}}, ins[31:20]}, f3);
      end
      rv_pkg::OPC_STORE: begin
        a = model_regs[rs1] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        off = 8'(a - WIN_BASE);
        val = model_regs[ins[24:20]];
        model_mem[off] = val[7:0];
        if (f3 != rv_pkg::F3_B) model_mem[off + 8'd1] = val[15:8];
        if (f3 == rv_pkg::F3_W) begin
          model_mem[off + 8'd2] = val[23:16];
          model_mem[off + 8'd3] = val[31:24];
        end
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) begin
      model_regs[rd] = val;
      from_load[rd] = (ins[6:0] == rv_pkg::OPC_LOAD);
    end
    model_pc = nxt;
  endfunction

  task automatic check(input int cat, input logic ok, input string msg);
    n_chk[cat]++;
    assert (ok) else begin
      n_err[cat]++;
      $display("FAIL %0t: %s", $time, msg);
    end
  endtask

  // bus request seen in the ack cycle against the model
  task automatic check_access(input rv_pkg::word_t ins);
    rv_pkg::word_t a;
    rv_pkg::word_t exp_dat;
    logic [3:0]    exp_sel;
    logic [4:0]    rs2;
    logic          lanes_ok;
    int            cat;
    rs2 = ins[24:20];
    if (ins[6:0] == rv_pkg::OPC_LOAD) begin
      a = model_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:20]};
    end else begin
      a = model_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
    end
    case (ins[14:12])
      rv_pkg::F3_B, rv_pkg::F3_BU: exp_sel = 4'b0001 << a[1:0];
      rv_pkg::F3_H, rv_pkg::F3_HU: exp_sel = 4'b0011 << a[1:0];
      default:                     exp_sel = 4'b1111;
    endcase
    if (ins[6:0] == rv_pkg::OPC_LOAD) begin
      check(B_LD, !wb_out.we && wb_out.adr == a && wb_out.sel == exp_sel,
            $sformatf("load adr %h we %b sel %b, expected %h %b", wb_out.adr, wb_out.we,
                      wb_out.sel, a, exp_sel));
    end else begin
      exp_dat = (rs2 == 5'd0) ? 32'h0 : model_regs[rs2] << (8 * a[1:0]);
      lanes_ok = 1'b1;
      for (int b = 0; b < 4; b++) begin
        if (exp_sel[b] && wb_out.dat[8*b +: 8] != exp_dat[8*b +: 8]) lanes_ok = 1'b0;
      end
      cat = (rs2 == 5'd0) ? B_X0 : (from_load[rs2] ? B_LD : B_ST);
      check(cat, wb_out.we && wb_out.adr == a && wb_out.sel == exp_sel && lanes_ok,
            $sformatf("store x%0d adr %h sel %b dat %h, expected %h %b %h", rs2,
                      wb_out.adr, wb_out.sel, wb_out.dat, a, exp_sel, exp_dat));
    end
  endtask

  task automatic finish_run();
    int total_chk;
    int total_err;
    string names [0:5];
    names = '{"reset", "sequencing", "stores", "loads", "wait", "x0"};
    total_chk = 0;
    total_err = 0;
    for (int k = 0; k < 6; k++) begin
      $display("%-10s checks %0d errors %0d", names[k], n_chk[k], n_err[k]);
      total_chk += n_chk[k];
      total_err += n_err[k];
    end
    $display("total checks %0d errors %0d", total_chk, total_err);
    if (total_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    for (int k = 0; k < 6; k++) begin
      n_chk[k] = 0;
      n_err[k] = 0;
    end
    for (int k = 0; k < 256; k++) begin
      slave_mem[k] = init_byte(WIN_BASE + 32'(k));
      model_mem[k] = init_byte(WIN_BASE + 32'(k));
    end
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
      from_load[k] = 1'b0;
    end
    model_pc = rv_pkg::RESET_PC;
    gen_program();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

  always @* inst = rom_lookup(pc); // instruction memory answers pc

  // wishbone slave with 0 to 3 wait cycles
  always @(posedge clk) begin
    int w;
    logic [7:0] o;
    if (reset) begin
      wb_in <= '0;
      in_req <= 1'b0;
    end else if (wb_in.ack) begin
      wb_in.ack <= 1'b0;
    end else if (wb_out.cyc && wb_out.stb) begin
      w = in_req ? wait_left : int'(rnd(4));
      in_req <= 1'b1;
      if (w == 0) begin
        in_req <= 1'b0;
        wb_in.ack <= 1'b1;
        o = 8'(wb_out.adr - WIN_BASE) & 8'hFC;
        if (wb_out.we) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_out.sel[b]) slave_mem[o + 8'(b)] <= wb_out.dat[8*b +: 8];
          end
        end else begin
          wb_in.dat <= {slave_mem[o + 8'd3], slave_mem[o + 8'd2],
                        slave_mem[o + 8'd1], slave_mem[o]};
        end
      end else begin
        wait_left <= w - 1;
      end
    end
  end

  always @(posedge clk) begin
    edges <= edges + 1;
    if (edges > MAX_CYCLES + 8) begin
      $display("timeout: program end not reached within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // compare at the falling edge, where DUT outputs are settled
  always @(negedge clk) begin
    rv_pkg::word_t ins;
    logic          is_mem;
    if (reset) begin
      if (edges > 0) begin
        check(B_RST, pc == rv_pkg::RESET_PC && !wb_out.cyc && !wb_out.stb,
              $sformatf("in reset pc %h cyc %b stb %b", pc, wb_out.cyc, wb_out.stb));
      end
    end else begin
      ins = rom_lookup(model_pc);
      is_mem = (ins[6:0] == rv_pkg::OPC_LOAD) || (ins[6:0] == rv_pkg::OPC_STORE);
      if (is_mem) seen_mem = 1'b1;
      if (!seen_mem) begin
        check(B_RST, !wb_out.cyc && !wb_out.stb, "bus active before any memory instruction");
      end
      if (is_mem && !wb_in.ack) begin
        check(B_WT, pc == model_pc, $sformatf("pc %h moved during wait, expected %h",
                                              pc, model_pc));
      end else begin
        check(B_SEQ, pc == model_pc, $sformatf("pc %h, expected %h", pc, model_pc));
      end
      if (is_mem && wb_in.ack) check_access(ins);
      if (!is_mem || wb_in.ack) step_model(ins);
      if (model_pc == end_pc) finish_run();
    end
  end

endmodule

/* filelist.f */
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_lsu.sv
verilog/rv_core_top.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

/* Makefile */
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the log decides the result, not the exit code of the binary
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
